/* verilog/imu_pkg.sv */
/*
 * Shared definitions for the IMU sampling subsystem.
 * Sample word layout, sensor register addresses and the Wishbone register map.
 */
package imu_pkg;

  // One three-axis sample as it arrives over SPI.
  // bytes[5] is XH and bytes[0] is ZL.
  typedef union packed {
    logic [5:0][7:0] bytes;
    struct packed {
      logic signed [15:0] x;
      logic signed [15:0] y;
      logic signed [15:0] z;
    } axes;
  } imu_sample_t;

  // First data register of each sensor
  localparam logic [7:0] ACC_BASE_REG = 8'h3B;
  localparam logic [7:0] GYR_BASE_REG = 8'h43;

  // MSB of the address byte selects a read
  localparam logic [7:0] SPI_READ_FLAG = 8'h80;

  // Address sent on the last transfer to clock out the final byte
  localparam logic [7:0] SPI_DUMMY_ADDR = 8'hFF;

  // Word offsets in the register bank
  localparam logic [2:0] REG_STATUS  = 3'd0;
  localparam logic [2:0] REG_ACC_X   = 3'd1;
  localparam logic [2:0] REG_ACC_Y   = 3'd2;
  localparam logic [2:0] REG_ACC_Z   = 3'd3;
  localparam logic [2:0] REG_GYR_X   = 3'd4;
  localparam logic [2:0] REG_GYR_Y   = 3'd5;
  localparam logic [2:0] REG_GYR_Z   = 3'd6;
  localparam logic [2:0] REG_CONTROL = 3'd7;

endpackage

/* verilog/spi_byte_master.sv */
/*
 * SPI mode-0 master for one byte per transfer, MSB first.
 * Pulse start with addr while busy is low; done strobes with the received byte.
 */
`timescale 1ns/1ps

module spi_byte_master #(
  parameter int CLK_DIV = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic [7:0] addr,
  input  logic       miso,
  output logic       sclk,
  output logic       mosi,
  output logic       busy,
  output logic       done,
  output logic [7:0] data
);

  // Half-period counter width, at least one bit
  localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [CW-1:0] div_cnt;
  logic [2:0]    bit_cnt;
  logic [7:0]    tx_sr;
  logic [7:0]    rx_sr;
  logic          half_tick;
  logic          rise_edge;
  logic          fall_edge;

  assign half_tick = busy && (div_cnt == CW'(CLK_DIV - 1));
  // sclk about to go high, sample miso
  assign rise_edge = half_tick && !sclk;
  // sclk about to go low, shift next bit out
  assign fall_edge = half_tick && sclk;

  // First bit is on the line before the first rising edge
  assign mosi = tx_sr[7];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      sclk    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      tx_sr   <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy    <= 1'b1;
          div_cnt <= '0;
          bit_cnt <= '0;
          tx_sr   <= addr;
        end
      end else if (half_tick) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (fall_edge) begin
          // Eighth falling edge ends the byte
          if (bit_cnt == 3'd7) begin
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 3'd1;
            tx_sr   <= {tx_sr[6:0], 1'b0};
          end
        end
      end else begin
        div_cnt <= div_cnt + CW'(1);
      end
    end
  end

  // Receive shifter and output byte
  always_ff @(posedge clk) begin
    if (rise_edge) begin
      rx_sr <= {rx_sr[6:0], miso};
    end
    // All eight bits are in by the last falling edge
    if (fall_edge && bit_cnt == 3'd7) begin
      data <= rx_sr;
    end
  end

endmodule

/* verilog/imu_burst_reader.sv */
/*
 * Burst reader for one IMU sensor over its own SPI bus.
 * On tick it reads six data registers from BASE_REG and pulses sample_valid.
 */
`timescale 1ns/1ps

module imu_burst_reader import imu_pkg::*; #(
  parameter logic [7:0] BASE_REG = ACC_BASE_REG,
  parameter int         CLK_DIV  = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        tick,
  input  logic        miso,
  output logic        sclk,
  output logic        mosi,
  output logic        ss,
  output imu_sample_t sample,
  output logic        sample_valid
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_BURST = 2'd1;
  localparam logic [1:0] ST_FLUSH = 2'd2;

  logic [1:0] state;
  // Transfer index, 0 to 6
  logic [2:0] idx;
  // Transfer issued and not yet done
  logic       pend;
  logic       start;
  logic [7:0] addr;
  logic       busy;
  logic       done;
  logic [7:0] rx_byte;
  logic       issue;

  spi_byte_master #(
    .CLK_DIV(CLK_DIV)
  ) u_spi (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .addr (addr),
    .miso (miso),
    .sclk (sclk),
    .mosi (mosi),
    .busy (busy),
    .done (done),
    .data (rx_byte)
  );

  // Next transfer goes out once the master is free
  assign issue = (state != ST_IDLE) && !busy && !pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      idx          <= '0;
      pend         <= 1'b0;
      start        <= 1'b0;
      ss           <= 1'b1;
      sample_valid <= 1'b0;
    end else begin
      start        <= 1'b0;
      sample_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Ticks during a burst never reach here, so they are dropped
          if (tick) begin
            state <= ST_BURST;
            idx   <= '0;
            ss    <= 1'b0;
          end
        end
        ST_BURST, ST_FLUSH: begin
          if (issue) begin
            start <= 1'b1;
            pend  <= 1'b1;
          end
          if (done) begin
            pend <= 1'b0;
            idx  <= idx + 3'd1;
            // Six register reads sent, one dummy left
            if (state == ST_BURST && idx == 3'd5) begin
              state <= ST_FLUSH;
            end
            if (state == ST_FLUSH) begin
              state        <= ST_IDLE;
              ss           <= 1'b1;
              sample_valid <= 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and sample bytes
  always_ff @(posedge clk) begin
    if (issue) begin
      if (state == ST_FLUSH) begin
        addr <= SPI_DUMMY_ADDR;
      end else begin
        addr <= SPI_READ_FLAG | (BASE_REG + 8'(idx));
      end
    end
    // Byte of transfer k belongs to the register of transfer k-1
    if (done && idx != 3'd0) begin
      sample.bytes[3'd6 - idx] <= rx_byte;
    end
  end

endmodule

/* verilog/sample_tick.sv */
/*
 * Periodic sample request, one pulse every TICK_DIV clocks while enabled.
 */
`timescale 1ns/1ps

module sample_tick #(
  parameter int TICK_DIV = 50000
) (
  input  logic clk,
  input  logic rst,
  input  logic enable,
  output logic tick
);

  localparam int TW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [TW-1:0] cnt;

  always_ff @(posedge clk) begin
    // Held cleared while disabled, so the period restarts on enable
    if (rst || !enable) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == TW'(TICK_DIV - 1)) begin
      cnt  <= '0;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt + TW'(1);
      tick <= 1'b0;
    end
  end

endmodule

/* verilog/imu_state_regs.sv */
/*
 * Wishbone classic register bank for the accelerometer and gyro samples.
 * Axis words are sign extended, STATUS holds fresh flags and sample counts.
 */
`timescale 1ns/1ps

module imu_state_regs import imu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [2:0]  adr,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack,
  input  imu_sample_t acc_sample,
  input  imu_sample_t gyr_sample,
  input  logic        acc_valid,
  input  logic        gyr_valid,
  output logic        enable
);

  imu_sample_t acc_q;
  imu_sample_t gyr_q;
  logic [7:0]  acc_cnt;
  logic [7:0]  gyr_cnt;
  logic        acc_fresh;
  logic        gyr_fresh;
  logic        access;
  logic        rd;
  logic [31:0] rd_word;

  // New request, ack goes out next cycle
  assign access = cyc && stb && !ack;
  assign rd     = access && !we;

  function automatic logic [31:0] sext16(input logic signed [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  always_comb begin
    case (adr)
      REG_STATUS:  rd_word = {8'd0, gyr_cnt, acc_cnt, 6'd0, gyr_fresh, acc_fresh};
      REG_ACC_X:   rd_word = sext16(acc_q.axes.x);
      REG_ACC_Y:   rd_word = sext16(acc_q.axes.y);
      REG_ACC_Z:   rd_word = sext16(acc_q.axes.z);
      REG_GYR_X:   rd_word = sext16(gyr_q.axes.x);
      REG_GYR_Y:   rd_word = sext16(gyr_q.axes.y);
      REG_GYR_Z:   rd_word = sext16(gyr_q.axes.z);
      REG_CONTROL: rd_word = {31'd0, enable};
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack       <= 1'b0;
      enable    <= 1'b0;
      acc_q     <= '0;
      gyr_q     <= '0;
      acc_cnt   <= '0;
      gyr_cnt   <= '0;
      acc_fresh <= 1'b0;
      gyr_fresh <= 1'b0;
    end else begin
      ack <= access;
      if (access && we && adr == REG_CONTROL) begin
        enable <= dat_i[0];
      end
      // Reading X consumes the sample; a new one in the same cycle wins
      if (rd && adr == REG_ACC_X) begin
        acc_fresh <= 1'b0;
      end
      if (rd && adr == REG_GYR_X) begin
        gyr_fresh <= 1'b0;
      end
      if (acc_valid) begin
        acc_q     <= acc_sample;
        acc_cnt   <= acc_cnt + 8'd1;
        acc_fresh <= 1'b1;
      end
      if (gyr_valid) begin
        gyr_q     <= gyr_sample;
        gyr_cnt   <= gyr_cnt + 8'd1;
        gyr_fresh <= 1'b1;
      end
    end
  end

  // Read data, valid with ack
  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= rd_word;
    end
  end

endmodule

/* verilog/imu_states.sv */
/*
 * Top level of the IMU sampling subsystem.
 * One tick starts both SPI burst readers; results are read over Wishbone.
 */
`timescale 1ns/1ps

module imu_states import imu_pkg::*; #(
  parameter int CLK_DIV  = 8,
  parameter int TICK_DIV = 50000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [2:0]  adr,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack,
  input  logic        acc_miso,
  output logic        acc_sclk,
  output logic        acc_mosi,
  output logic        acc_ss,
  input  logic        gyr_miso,
  output logic        gyr_sclk,
  output logic        gyr_mosi,
  output logic        gyr_ss
);

  logic        tick;
  logic        enable;
  imu_sample_t acc_sample;
  imu_sample_t gyr_sample;
  logic        acc_valid;
  logic        gyr_valid;

  sample_tick #(
    .TICK_DIV(TICK_DIV)
  ) u_tick (
    .clk   (clk),
    .rst   (rst),
    .enable(enable),
    .tick  (tick)
  );

  // Accelerometer bus
  imu_burst_reader #(
    .BASE_REG(ACC_BASE_REG),
    .CLK_DIV (CLK_DIV)
  ) u_acc (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .miso        (acc_miso),
    .sclk        (acc_sclk),
    .mosi        (acc_mosi),
    .ss          (acc_ss),
    .sample      (acc_sample),
    .sample_valid(acc_valid)
  );

  // Gyro bus
  imu_burst_reader #(
    .BASE_REG(GYR_BASE_REG),
    .CLK_DIV (CLK_DIV)
  ) u_gyr (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .miso        (gyr_miso),
    .sclk        (gyr_sclk),
    .mosi        (gyr_mosi),
    .ss          (gyr_ss),
    .sample      (gyr_sample),
    .sample_valid(gyr_valid)
  );

  imu_state_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_i     (dat_i),
    .dat_o     (dat_o),
    .ack       (ack),
    .acc_sample(acc_sample),
    .gyr_sample(gyr_sample),
    .acc_valid (acc_valid),
    .gyr_valid (gyr_valid),
    .enable    (enable)
  );

endmodule

/* verif/imu_sensor_model.sv */
/*
 * Behavioral SPI mode-0 slave standing in for one IMU sensor.
 * The testbench writes regs directly; each byte returns the register
 * addressed by the previous byte of the same burst.
 */
`timescale 1ns/1ps

module imu_sensor_model (
  input  logic ss,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  // Sensor register file, 7-bit address
  logic [7:0] regs [0:127];
  logic [7:0] tx_sr;
  logic [7:0] rx_sr;
  int         bit_cnt;

  // MSB first, current bit always on the line
  assign miso = tx_sr[7];

  initial begin
    for (int i = 0; i < 128; i++) begin
      regs[i] = 8'h00;
    end
    tx_sr   = 8'h00;
    rx_sr   = 8'h00;
    bit_cnt = 0;
  end

  // New burst, nothing addressed yet so the first byte is zero
  always @(negedge ss) begin
    tx_sr   = 8'h00;
    bit_cnt = 0;
  end

  // Mode 0 sample edge
  always @(posedge sclk) begin
    if (ss === 1'b0) begin
      rx_sr   = {rx_sr[6:0], mosi};
      bit_cnt = bit_cnt + 1;
    end
  end

  // Mode 0 shift edge
  always @(negedge sclk) begin
    if (ss === 1'b0) begin
      if (bit_cnt == 8) begin
        // Address byte complete, preload its register for the next byte
        bit_cnt = 0;
        if (rx_sr[7]) begin
          tx_sr = regs[rx_sr[6:0]];
        end else begin
          tx_sr = 8'h00;
        end
      end else begin
        tx_sr = {tx_sr[6:0], 1'b0};
      end
    end
  end

endmodule

/* verif/tb_imu_states.sv */
/*
 * Testbench for the IMU sampling subsystem.
 * Sensor bytes and control values come from the stimulus file; results
 * are read back over Wishbone with random idle gaps between accesses.
 */
`timescale 1ns/1ps

module tb_imu_states import imu_pkg::*; ();

  localparam int CLK_DIV      = 2;
  localparam int TICK_DIV     = 4000;
  localparam int ACK_LIMIT    = 16;
  localparam int POLL_GAP     = 20;
  localparam int SAMPLE_LIMIT = 4 * TICK_DIV;
  localparam int SETTLE_GAP   = 400;
  localparam int SETTLE_POLLS = 8;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [31:0] dat_i;
  logic [31:0] dat_o;
  logic        ack;
  logic        acc_miso;
  logic        acc_sclk;
  logic        acc_mosi;
  logic        acc_ss;
  logic        gyr_miso;
  logic        gyr_sclk;
  logic        gyr_mosi;
  logic        gyr_ss;

  logic [7:0]  stim [0:255];
  logic [31:0] lfsr;
  int          cycle_count = 0;
  int          value_errors = 0;
  int          fail_count = 0;

  imu_states #(
    .CLK_DIV (CLK_DIV),
    .TICK_DIV(TICK_DIV)
  ) dut0 (
    .clk     (clk),
    .rst     (rst),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_i   (dat_i),
    .dat_o   (dat_o),
    .ack     (ack),
    .acc_miso(acc_miso),
    .acc_sclk(acc_sclk),
    .acc_mosi(acc_mosi),
    .acc_ss  (acc_ss),
    .gyr_miso(gyr_miso),
    .gyr_sclk(gyr_sclk),
    .gyr_mosi(gyr_mosi),
    .gyr_ss  (gyr_ss)
  );

  imu_sensor_model acc_model (.ss(acc_ss), .sclk(acc_sclk), .mosi(acc_mosi), .miso(acc_miso));
  imu_sensor_model gyr_model (.ss(gyr_ss), .sclk(gyr_sclk), .mosi(gyr_mosi), .miso(gyr_miso));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Free-running cycle count for the sample timeouts
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Right-shift Galois LFSR
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // Big-endian byte pair as a sign-extended word
  function automatic logic [31:0] axis_word(input logic [7:0] hi, input logic [7:0] lo);
    return {{16{hi[7]}}, hi, lo};
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // 0 to 7 idle cycles from three LFSR bits
  task automatic random_idle();
    int gap;
    gap = 0;
    repeat (3) begin
      gap  = (gap << 1) | lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
    repeat (gap) @(negedge clk);
  endtask

  // One Wishbone classic access with ack latency and width checked
  task automatic bus_access(input logic write, input logic [2:0] a, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int cycles;
    random_idle();
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_i = wdata;
    @(negedge clk);
    cycles = 1;
    while (ack !== 1'b1 && cycles < ACK_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== 1'b1) begin
      $display("timeout: no ack for access to word %0d", a);
      fail_count++;
      rdata = 'x;
    end else begin
      check_word("ack latency", cycles, 32'd1);
      rdata = dat_o;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge clk);
    check_word("ack", {31'd0, ack}, 32'd0);
  endtask

  task automatic read_reg(input logic [2:0] a, output logic [31:0] d);
    bus_access(1'b0, a, 32'd0, d);
  endtask

  task automatic write_reg(input logic [2:0] a, input logic [31:0] d);
    logic [31:0] unused;
    bus_access(1'b1, a, d, unused);
  endtask

  // Poll STATUS until both counts moved on by need
  task automatic wait_samples(input logic [7:0] acc_base, input logic [7:0] gyr_base,
                              input int need, output logic [31:0] status);
    int         t0;
    logic [7:0] acc_adv;
    logic [7:0] gyr_adv;
    logic       reached;
    t0 = cycle_count;
    read_reg(REG_STATUS, status);
    acc_adv = status[15:8] - acc_base;
    gyr_adv = status[23:16] - gyr_base;
    reached = (acc_adv >= need) && (gyr_adv >= need);
    while (reached !== 1'b1 && cycle_count - t0 < SAMPLE_LIMIT) begin
      repeat (POLL_GAP) @(negedge clk);
      read_reg(REG_STATUS, status);
      acc_adv = status[15:8] - acc_base;
      gyr_adv = status[23:16] - gyr_base;
      reached = (acc_adv >= need) && (gyr_adv >= need);
    end
    if (reached !== 1'b1) begin
      $display("timeout: sample counts did not advance by %0d", need);
      fail_count++;
    end
  endtask

  // A burst already running may still finish after disable
  task automatic wait_settled(output logic [31:0] status);
    logic [31:0] prev;
    int          polls;
    read_reg(REG_STATUS, prev);
    repeat (SETTLE_GAP) @(negedge clk);
    read_reg(REG_STATUS, status);
    polls = 1;
    while (status[23:8] !== prev[23:8] && polls < SETTLE_POLLS) begin
      prev = status;
      repeat (SETTLE_GAP) @(negedge clk);
      read_reg(REG_STATUS, status);
      polls++;
    end
    if (status[23:8] !== prev[23:8]) begin
      $display("timeout: sample counts kept changing after disable");
      fail_count++;
    end
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] status;
    logic [31:0] prev;
    logic        spi_busy;
    int          rounds;
    int          base;
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = 3'd0;
    dat_i = 32'd0;
    lfsr  = 32'h7d8d2a83;
    $readmemh("verif/imu_stimulus.txt", stim);
    rounds = stim[0];
    if ($isunknown(stim[0]) || rounds == 0) begin
      $display("stimulus file holds no test rounds");
      fail_count++;
      rounds = 0;
    end
    // Eight rising edges with reset held
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset state and idle SPI buses while disabled
    read_reg(REG_STATUS, word);
    check_word("status", word, 32'd0);
    read_reg(REG_CONTROL, word);
    check_word("control", word, 32'd0);
    spi_busy = 1'b0;
    repeat (2 * TICK_DIV) begin
      @(negedge clk);
      if (acc_ss !== 1'b1 || gyr_ss !== 1'b1 || acc_sclk !== 1'b0 || gyr_sclk !== 1'b0) begin
        spi_busy = 1'b1;
      end
    end
    if (spi_busy) begin
      $display("SPI bus active while sampling was disabled");
      fail_count++;
    end

    // Enable and first samples
    write_reg(REG_CONTROL, {24'd0, stim[1]});
    read_reg(REG_CONTROL, word);
    check_word("control", word, {24'd0, stim[2]});
    wait_samples(8'd0, 8'd0, 1, status);
    check_word("status fresh", {30'd0, status[1:0]}, 32'h3);

    // Axis decode over two samples per round so no burst straddles the load
    for (int r = 0; r < rounds; r++) begin
      base = 5 + 12 * r;
      for (int i = 0; i < 6; i++) begin
        acc_model.regs[ACC_BASE_REG[6:0] + i] = stim[base + i];
        gyr_model.regs[GYR_BASE_REG[6:0] + i] = stim[base + 6 + i];
      end
      read_reg(REG_STATUS, status);
      wait_samples(status[15:8], status[23:16], 2, status);
      for (int i = 0; i < 3; i++) begin
        read_reg(REG_ACC_X + 3'(i), word);
        check_word($sformatf("acc_%c", 8'h78 + i), word,
                   axis_word(stim[base + 2 * i], stim[base + 2 * i + 1]));
        read_reg(REG_GYR_X + 3'(i), word);
        check_word($sformatf("gyr_%c", 8'h78 + i), word,
                   axis_word(stim[base + 6 + 2 * i], stim[base + 7 + 2 * i]));
      end
    end

    // Fresh flags cleared one at a time by the X reads
    read_reg(REG_STATUS, status);
    wait_samples(status[15:8], status[23:16], 1, status);
    check_word("status fresh", {30'd0, status[1:0]}, 32'h3);
    prev = status;
    read_reg(REG_ACC_X, word);
    read_reg(REG_STATUS, status);
    check_word("status", status, {prev[31:2], 2'b10});
    read_reg(REG_GYR_X, word);
    read_reg(REG_STATUS, status);
    check_word("status", status, {prev[31:2], 2'b00});
    wait_samples(status[15:8], status[23:16], 1, status);
    check_word("status fresh", {30'd0, status[1:0]}, 32'h3);

    // Counts freeze after disable
    write_reg(REG_CONTROL, {24'd0, stim[3]});
    read_reg(REG_CONTROL, word);
    check_word("control", word, {24'd0, stim[4]});
    wait_settled(status);
    repeat (3 * TICK_DIV) @(negedge clk);
    read_reg(REG_STATUS, word);
    check_word("status counts", {16'd0, word[23:8]}, {16'd0, status[23:8]});

    $display("value errors: %0d, other failures: %0d", value_errors, fail_count);
    if (value_errors == 0 && fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verif/imu_stimulus.txt */
// Header: round count, enable write, enable readback, disable write, disable readback
// Each round: accel regs 3B..40 then gyro regs 43..48, bytes XH XL YH YL ZH ZL
06 01 01 00 00
// round 0
12 34 56 78 9A BC
01 02 03 04 05 06
// round 1, full-scale values
80 00 7F FF FF FF
00 00 80 01 7F 00
// round 2
FF 00 00 FF C3 5A
A5 5A 3C C3 0F F0
// round 3
00 01 FF FE 40 00
E0 00 1F FF 80 80
// round 4
DE AD BE EF 00 00
CA FE F0 0D 7F 7F
// round 5
55 AA AA 55 01 80
8F 11 22 33 F4 44

/* all.f */
verilog/imu_pkg.sv
verilog/spi_byte_master.sv
verilog/imu_burst_reader.sv
verilog/sample_tick.sv
verilog/imu_state_regs.sv
verilog/imu_states.sv
verif/imu_sensor_model.sv
verif/tb_imu_states.sv

/* Bender.yml */
package:
  name: imu_states

sources:
  - verilog/imu_pkg.sv
  - verilog/spi_byte_master.sv
  - verilog/imu_burst_reader.sv
  - verilog/sample_tick.sv
  - verilog/imu_state_regs.sv
  - verilog/imu_states.sv
  - target: test
    files:
      - verif/imu_sensor_model.sv
      - verif/tb_imu_states.sv
